// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_load_store_unit \
    -f sources.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sim/tb_load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit;

    localparam int RAM_WORDS = 256;
    localparam int ATTR_DEPTH = 2;
    localparam int ID_W = ls_pkg::ID_W;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);
    localparam int PERIPH_IDX_W = $clog2(ls_pkg::PERIPH_REGS);
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h5039_abb3;

    logic clk;
    logic rst;
    logic issue_valid;
    logic [31:0] rs1;
    logic [11:0] offset;
    logic [31:0] rs2;
    ls_pkg::ls_fn3_t fn3;
    logic is_load;
    logic is_store;
    logic [ID_W-1:0] id;
    logic exc_ack;
    logic issue_ready;
    logic wb_done;
    logic [31:0] wb_data;
    logic [ID_W-1:0] wb_id;
    logic exc_valid;
    ls_pkg::ls_exc_t exc_code;
    logic [31:0] exc_tval;
    logic [ID_W-1:0] exc_id;

    // Reference memories
    logic [31:0] ram_model [RAM_WORDS];
    logic [31:0] periph_model [ls_pkg::PERIPH_REGS];
    int ram_known[$];

    // Expected writebacks in issue order
    // An expected cycle of 0 matches any cycle
    logic [31:0] exp_data[$];
    logic [ID_W-1:0] exp_id[$];
    int exp_cycle[$];

    logic [31:0] lfsr_state;
    logic [ID_W-1:0] next_id;
    logic [ID_W-1:0] last_id;
    int cycle = 0;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    string cur_test;

    logic [31:0] mon_data;
    logic [ID_W-1:0] mon_id;
    int mon_cycle;

    load_store_unit #(
        .RAM_WORDS  (RAM_WORDS),
        .ATTR_DEPTH (ATTR_DEPTH)
    ) DUT (
        .clk, .rst, .issue_valid, .rs1, .offset, .rs2, .fn3, .is_load, .is_store,
        .id, .exc_ack, .issue_ready, .wb_done, .wb_data, .wb_id,
        .exc_valid, .exc_code, .exc_tval, .exc_id
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Result: FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Random numbers and models
    //////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (addr >= ls_pkg::PERIPH_BASE) begin
            return periph_model[addr[PERIPH_IDX_W+1:2]];
        end
        return ram_model[addr[RAM_IDX_W+1:2]];
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] word,
                                                input ls_pkg::ls_fn3_t width,
                                                input logic [1:0] off,
                                                input logic [31:0] data);
        logic [31:0] w;
        w = word;
        case (width)
            ls_pkg::LS_B: w[{off, 3'b000} +: 8] = data[7:0];
            ls_pkg::LS_H: w[{off, 3'b000} +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    // Load result as the ISA defines it
    function automatic logic [31:0] expect_load(input logic [31:0] word,
                                                input ls_pkg::ls_fn3_t width,
                                                input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> {off, 3'b000};
        case (width)
            ls_pkg::LS_B: return {{24{sh[7]}}, sh[7:0]};
            ls_pkg::L_BU: return {24'h0, sh[7:0]};
            ls_pkg::LS_H: return {{16{sh[15]}}, sh[15:0]};
            ls_pkg::L_HU: return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] exp,
                            input logic [ID_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected id %h, actual id %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_exc(input string name, input ls_pkg::ls_exc_t exp,
                             input ls_pkg::ls_exc_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    // Writeback monitor
    always @(negedge clk) begin
        if (!rst && wb_done) begin
            if (exp_data.size() == 0) begin
                $display("[ERROR] %s: wb_done with no load outstanding", cur_test);
                errors++;
            end else begin
                mon_data = exp_data.pop_front();
                mon_id = exp_id.pop_front();
                mon_cycle = exp_cycle.pop_front();
                check_data(cur_test, mon_data, wb_data);
                check_id(cur_test, mon_id, wb_id);
                if (mon_cycle != 0 && mon_cycle != cycle) begin
                    $display("[ERROR] %s: wb_done came at cycle %0d instead of cycle %0d",
                             cur_test, cycle, mon_cycle);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////
    // Driving helpers
    //////////////////////////////

    // Positive lat checks the done cycle
    // Zero lat checks only the order
    // Negative lat expects no writeback
    task automatic issue(input logic [31:0] addr, input ls_pkg::ls_fn3_t width,
                         input bit load, input logic [31:0] wdata,
                         input int lat, input logic [31:0] expected);
        logic [11:0] imm;
        imm = 12'(rand_bits(12));
        while (!issue_ready) begin
            @(negedge clk);
        end
        offset = imm;
        rs1 = addr - {{20{imm[11]}}, imm};
        rs2 = wdata;
        fn3 = width;
        is_load = load;
        is_store = !load;
        id = next_id;
        issue_valid = 1'b1;
        last_id = next_id;
        if (load && lat >= 0) begin
            exp_data.push_back(expected);
            exp_id.push_back(next_id);
            exp_cycle.push_back(lat > 0 ? cycle + lat : 0);
        end
        next_id = next_id + 1'b1;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic do_store(input logic [31:0] addr, input ls_pkg::ls_fn3_t width,
                            input logic [31:0] data);
        logic [31:0] w;
        w = merge_store(model_word(addr), width, addr[1:0], data);
        if (addr >= ls_pkg::PERIPH_BASE) begin
            periph_model[addr[PERIPH_IDX_W+1:2]] = w;
        end else begin
            ram_model[addr[RAM_IDX_W+1:2]] = w;
        end
        issue(addr, width, 1'b0, data, -1, '0);
    endtask

    task automatic do_load(input logic [31:0] addr, input ls_pkg::ls_fn3_t width, input int lat);
        issue(addr, width, 1'b1, '0, lat, expect_load(model_word(addr), width, addr[1:0]));
    endtask

    task automatic fault_access(input logic [31:0] addr, input ls_pkg::ls_fn3_t width,
                                input bit load, input ls_pkg::ls_exc_t code);
        issue(addr, width, load, rand_bits(32), -1, '0);
        if (!exc_valid) begin
            $display("[ERROR] %s: no exception raised for address %h", cur_test, addr);
            errors++;
        end else begin
            check_exc(cur_test, code, exc_code);
            check_data(cur_test, addr, exc_tval);
            check_id(cur_test, last_id, exc_id);
        end
        repeat (2) @(negedge clk);
        if (!exc_valid) begin
            $display("[ERROR] %s: exception dropped before it was acknowledged", cur_test);
            errors++;
        end
        exc_ack = 1'b1;
        @(negedge clk);
        exc_ack = 1'b0;
        if (exc_valid) begin
            $display("[ERROR] %s: exception still valid after exc_ack", cur_test);
            errors++;
        end
    endtask

    task automatic wait_drain;
        while (exp_data.size() > 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test;
        if (errors == errors_at_start) begin
            $display("[PASS] %s", cur_test);
        end else begin
            $display("[FAIL] %s with %0d errors", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state;
        start_test("reset_state");
        if (wb_done !== 1'b0 || exc_valid !== 1'b0 || issue_ready !== 1'b1) begin
            $display("[ERROR] %s: outputs not idle after reset", cur_test);
            errors++;
        end
        end_test();
    endtask

    task automatic test_ram_words;
        int idx;
        start_test("ram_words");
        for (int i = 0; i < 8; i++) begin
            idx = int'(rand_bits(RAM_IDX_W));
            do_store(32'(idx * 4), ls_pkg::LS_W, rand_bits(32));
            ram_known.push_back(idx);
        end
        foreach (ram_known[i]) begin
            do_load(32'(ram_known[i] * 4), ls_pkg::LS_W, 1);
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_ram_subword;
        logic [31:0] base;
        start_test("ram_subword");
        for (int w = 0; w < 2; w++) begin
            base = rand_bits(RAM_IDX_W) << 2;
            ram_known.push_back(int'(base >> 2));
            do_store(base, ls_pkg::LS_W, rand_bits(32));
            for (int off = 0; off < 4; off++) begin
                do_store(base + 32'(off), ls_pkg::LS_B, rand_bits(32));
                do_load(base + 32'(off), ls_pkg::LS_B, 1);
                do_load(base + 32'(off), ls_pkg::L_BU, 1);
                // Whole word shows which bytes the store touched
                do_load(base, ls_pkg::LS_W, 1);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_store(base + 32'(off), ls_pkg::LS_H, rand_bits(32));
                do_load(base + 32'(off), ls_pkg::LS_H, 1);
                do_load(base + 32'(off), ls_pkg::L_HU, 1);
                do_load(base, ls_pkg::LS_W, 1);
            end
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_periph_regs;
        start_test("periph_regs");
        for (int r = 0; r < ls_pkg::PERIPH_REGS; r++) begin
            do_store(ls_pkg::PERIPH_BASE + 32'(r * 4), ls_pkg::LS_W, rand_bits(32));
        end
        do_store(ls_pkg::PERIPH_BASE + 32'd13, ls_pkg::LS_B, rand_bits(32));
        do_store(ls_pkg::PERIPH_BASE + 32'd22, ls_pkg::LS_H, rand_bits(32));
        // Back to back with up to two in flight
        for (int r = 0; r < ls_pkg::PERIPH_REGS; r++) begin
            do_load(ls_pkg::PERIPH_BASE + 32'(r * 4), ls_pkg::LS_W, 2);
        end
        do_load(ls_pkg::PERIPH_BASE + 32'd13, ls_pkg::LS_B, 2);
        do_load(ls_pkg::PERIPH_BASE + 32'd22, ls_pkg::L_HU, 2);
        wait_drain();
        end_test();
    endtask

    task automatic test_misaligned;
        logic [31:0] base;
        start_test("misaligned");
        base = 32'(ram_known[0] * 4);
        fault_access(base + 32'd1, ls_pkg::LS_H, 1'b1, ls_pkg::LOAD_ADDR_MISALIGNED);
        fault_access(base + 32'd3, ls_pkg::L_HU, 1'b1, ls_pkg::LOAD_ADDR_MISALIGNED);
        fault_access(base + 32'd2, ls_pkg::LS_W, 1'b1, ls_pkg::LOAD_ADDR_MISALIGNED);
        fault_access(base + 32'd1, ls_pkg::LS_H, 1'b0, ls_pkg::STORE_ADDR_MISALIGNED);
        fault_access(base + 32'd2, ls_pkg::LS_W, 1'b0, ls_pkg::STORE_ADDR_MISALIGNED);
        fault_access(base + 32'd3, ls_pkg::LS_W, 1'b0, ls_pkg::STORE_ADDR_MISALIGNED);
        // Word must be untouched
        do_load(base, ls_pkg::LS_W, 1);
        wait_drain();
        end_test();
    endtask

    task automatic test_unmapped;
        logic [31:0] ram_end;
        start_test("unmapped");
        ram_end = 32'(RAM_WORDS * 4);
        do_store(32'h0, ls_pkg::LS_W, rand_bits(32));
        fault_access(ram_end, ls_pkg::LS_W, 1'b1, ls_pkg::LOAD_ACCESS_FAULT);
        fault_access(ram_end, ls_pkg::LS_W, 1'b0, ls_pkg::STORE_ACCESS_FAULT);
        fault_access(ls_pkg::PERIPH_BASE + 32'(ls_pkg::PERIPH_REGS * 4), ls_pkg::LS_W, 1'b0,
                     ls_pkg::STORE_ACCESS_FAULT);
        fault_access(32'h4000_0000, ls_pkg::LS_B, 1'b1, ls_pkg::LOAD_ACCESS_FAULT);
        fault_access(32'hffff_ffff, ls_pkg::LS_B, 1'b0, ls_pkg::STORE_ACCESS_FAULT);
        // Misalignment wins over an unmapped address
        fault_access(ram_end + 32'd1, ls_pkg::LS_W, 1'b1, ls_pkg::LOAD_ADDR_MISALIGNED);
        do_load(32'h0, ls_pkg::LS_W, 1);
        wait_drain();
        do_load(ls_pkg::PERIPH_BASE, ls_pkg::LS_W, 2);
        wait_drain();
        end_test();
    endtask

    task automatic test_alternating;
        int r;
        int k;
        start_test("alternating");
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                r = int'(rand_bits(PERIPH_IDX_W));
                do_load(ls_pkg::PERIPH_BASE + 32'(r * 4), ls_pkg::LS_W, 0);
            end else begin
                k = int'(rand_bits(8)) % ram_known.size();
                do_load(32'(ram_known[k] * 4) + rand_bits(2), ls_pkg::LS_B, 0);
            end
        end
        wait_drain();
        end_test();
    endtask

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        rs1 = '0;
        offset = '0;
        rs2 = '0;
        fn3 = ls_pkg::LS_W;
        is_load = 1'b0;
        is_store = 1'b0;
        id = '0;
        exc_ack = 1'b0;
        lfsr_state = SEED;
        next_id = '0;
        last_id = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "reset";
        for (int r = 0; r < ls_pkg::PERIPH_REGS; r++) begin
            periph_model[r] = '0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_ram_words();
        test_ram_subword();
        test_periph_regs();
        test_misaligned();
        test_unmapped();
        test_alternating();

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit #(
    parameter int RAM_WORDS = 256,
    parameter int ATTR_DEPTH = 2
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        issue_valid,
    input  wire [31:0]                 rs1,
    input  wire [11:0]                 offset,
    input  wire [31:0]                 rs2,
    input  wire ls_pkg::ls_fn3_t       fn3,
    input  wire                        is_load,
    input  wire                        is_store,
    input  wire [ls_pkg::ID_W-1:0]     id,
    input  wire                        exc_ack,
    output logic                       issue_ready,
    output logic                       wb_done,
    output logic [31:0]                wb_data,
    output logic [ls_pkg::ID_W-1:0]    wb_id,
    output logic                       exc_valid,
    output ls_pkg::ls_exc_t            exc_code,
    output logic [31:0]                exc_tval,
    output logic [ls_pkg::ID_W-1:0]    exc_id
);

    logic issue_accept;
    logic [31:0] address;
    logic [3:0] be;
    ls_pkg::ls_unit_t unit;
    logic access_ok;
    logic [31:0] lane_data;

    logic conflict;
    logic live_go;
    logic capture;
    logic replay;
    logic stall_pending;
    ls_pkg::ls_unit_t last_unit;

    // Request parked during a unit switch
    logic [31:0] h_address;
    logic [3:0] h_be;
    ls_pkg::ls_unit_t h_unit;
    logic h_is_store;
    logic [31:0] h_wdata;
    ls_pkg::ls_fn3_t h_fn3;
    logic [ls_pkg::ID_W-1:0] h_id;

    logic d_valid;
    logic [31:0] d_address;
    logic [3:0] d_be;
    ls_pkg::ls_unit_t d_unit;
    logic d_is_store;
    logic [31:0] d_wdata;
    ls_pkg::ls_fn3_t d_fn3;
    logic [ls_pkg::ID_W-1:0] d_id;

    logic ram_req;
    logic periph_req;
    logic [31:0] ram_rdata;
    logic ram_rvalid;
    logic [31:0] periph_rdata;
    logic periph_rvalid;

    logic push;
    logic pop;
    ls_pkg::ls_attr_t attr_in;
    ls_pkg::ls_attr_t attr_head;
    logic fifo_full;
    logic fifo_empty;
    logic [31:0] muxed_word;

    //////////////////////////////
    // Issue and unit switch stall
    //////////////////////////////

    assign issue_ready = ~fifo_full & ~stall_pending;
    assign issue_accept = issue_valid & issue_ready & (is_load | is_store);

    ls_addr_gen #(.RAM_WORDS(RAM_WORDS)) addr_gen (
        .clk, .rst,
        .issue_valid (issue_accept),
        .rs1, .offset, .fn3, .is_store, .id, .exc_ack,
        .address, .be, .unit, .access_ok,
        .exc_valid, .exc_code, .exc_tval, .exc_id
    );

    // Store data copied onto every lane the enables may pick
    always_comb begin
        case (fn3[1:0])
            2'b00: lane_data = {4{rs2[7:0]}};
            2'b01: lane_data = {2{rs2[15:0]}};
            default: lane_data = rs2;
        endcase
    end

    // Loads still out on the other unit block this access
    assign conflict = (unit != last_unit) & ~fifo_empty;
    assign live_go = issue_accept & access_ok & ~conflict;
    assign capture = issue_accept & access_ok & conflict;
    assign replay = stall_pending & fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_pending <= 1'b0;
        end else if (capture) begin
            stall_pending <= 1'b1;
        end else if (replay) begin
            stall_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            h_address <= address;
            h_be <= be;
            h_unit <= unit;
            h_is_store <= is_store;
            h_wdata <= lane_data;
            h_fn3 <= fn3;
            h_id <= id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= ls_pkg::UNIT_RAM;
        end else if (push) begin
            last_unit <= d_unit;
        end
    end

    //////////////////////////////
    // Dispatch to the sub-units
    //////////////////////////////

    assign d_valid = live_go | replay;
    assign d_address = stall_pending ? h_address : address;
    assign d_be = stall_pending ? h_be : be;
    assign d_unit = stall_pending ? h_unit : unit;
    assign d_is_store = stall_pending ? h_is_store : is_store;
    assign d_wdata = stall_pending ? h_wdata : lane_data;
    assign d_fn3 = stall_pending ? h_fn3 : fn3;
    assign d_id = stall_pending ? h_id : id;

    assign ram_req = d_valid & (d_unit == ls_pkg::UNIT_RAM);
    assign periph_req = d_valid & (d_unit == ls_pkg::UNIT_PERIPH);

    ls_local_ram #(.RAM_WORDS(RAM_WORDS)) local_ram (
        .clk,
        .req      (ram_req),
        .is_store (d_is_store),
        .address  (d_address),
        .be       (d_be),
        .wdata    (d_wdata),
        .rdata    (ram_rdata),
        .rvalid   (ram_rvalid)
    );

    ls_periph_regs periph_regs (
        .clk, .rst,
        .req      (periph_req),
        .is_store (d_is_store),
        .address  (d_address),
        .be       (d_be),
        .wdata    (d_wdata),
        .rdata    (periph_rdata),
        .rvalid   (periph_rvalid)
    );

    //////////////////////////////
    // Load attributes and results
    //////////////////////////////

    assign push = d_valid & ~d_is_store;
    assign pop = ram_rvalid | periph_rvalid;

    always_comb begin
        attr_in.width = d_fn3;
        attr_in.byte_addr = d_address[1:0];
        attr_in.id = d_id;
        attr_in.unit = d_unit;
    end

    ls_attr_fifo #(.DEPTH(ATTR_DEPTH)) attr_fifo (
        .clk, .rst,
        .push, .pop,
        .data_in  (attr_in),
        .data_out (attr_head),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

    assign muxed_word = (attr_head.unit == ls_pkg::UNIT_PERIPH) ? periph_rdata : ram_rdata;

    ls_load_align load_align (
        .word (muxed_word),
        .attr (attr_head),
        .data (wb_data)
    );

    assign wb_done = pop;
    assign wb_id = attr_head.id;

    // Returned data must belong to the oldest load in flight
    rvalid_matches_head: assert property (@(posedge clk) disable iff (rst)
        (ram_rvalid || periph_rvalid) |->
            (!fifo_empty && !(ram_rvalid && periph_rvalid) &&
             (attr_head.unit == (periph_rvalid ? ls_pkg::UNIT_PERIPH : ls_pkg::UNIT_RAM))))
        else $error("load data returned without a matching attribute entry");

endmodule

`default_nettype wire

// File: source/ls_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ls_addr_gen #(
    parameter int RAM_WORDS = 256
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        issue_valid,
    input  wire [31:0]                 rs1,
    input  wire [11:0]                 offset,
    input  wire ls_pkg::ls_fn3_t       fn3,
    input  wire                        is_store,
    input  wire [ls_pkg::ID_W-1:0]     id,
    input  wire                        exc_ack,
    output logic [31:0]                address,
    output logic [3:0]                 be,
    output ls_pkg::ls_unit_t           unit,
    output logic                       access_ok,
    output logic                       exc_valid,
    output ls_pkg::ls_exc_t            exc_code,
    output logic [31:0]                exc_tval,
    output logic [ls_pkg::ID_W-1:0]    exc_id
);

    localparam logic [31:0] RAM_END = 32'(RAM_WORDS * 4);
    localparam logic [31:0] PERIPH_END = ls_pkg::PERIPH_BASE + 32'(ls_pkg::PERIPH_REGS * 4);

    logic in_ram;
    logic in_periph;
    logic misaligned;
    logic new_exc;

    // Base plus sign-extended immediate
    assign address = rs1 + {{20{offset[11]}}, offset};

    always_comb begin
        case (fn3)
            ls_pkg::LS_H, ls_pkg::L_HU: misaligned = address[0];
            ls_pkg::LS_W: misaligned = |address[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Byte enables sized by the low two bits of fn3
    always_comb begin
        be = 4'b0000;
        case (fn3[1:0])
            2'b00: be[address[1:0]] = 1'b1;
            2'b01: be = address[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
    end

    //////////////////////////////
    // Range decode
    //////////////////////////////

    assign in_ram = address < RAM_END;
    assign in_periph = (address >= ls_pkg::PERIPH_BASE) && (address < PERIPH_END);
    assign unit = in_periph ? ls_pkg::UNIT_PERIPH : ls_pkg::UNIT_RAM;
    assign access_ok = ~misaligned & (in_ram | in_periph);
    assign new_exc = issue_valid & ~access_ok;

    //////////////////////////////
    // Held exception
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= (exc_valid & ~exc_ack) | new_exc;
        end
    end

    // First fault wins until it is acknowledged
    always_ff @(posedge clk) begin
        if (new_exc && (!exc_valid || exc_ack)) begin
            if (misaligned) begin
                exc_code <= is_store ? ls_pkg::STORE_ADDR_MISALIGNED
                                     : ls_pkg::LOAD_ADDR_MISALIGNED;
            end else begin
                exc_code <= is_store ? ls_pkg::STORE_ACCESS_FAULT
                                     : ls_pkg::LOAD_ACCESS_FAULT;
            end
            exc_tval <= address;
            exc_id <= id;
        end
    end

    exc_held_stable: assert property (@(posedge clk) disable iff (rst)
        (exc_valid && !exc_ack) |=> (exc_valid && $stable(exc_code)))
        else $error("exception code changed while held");

endmodule

`default_nettype wire

// File: source/ls_attr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ls_attr_fifo #(
    parameter int DEPTH = 2
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   push,
    input  wire ls_pkg::ls_attr_t data_in,
    input  wire                   pop,
    output ls_pkg::ls_attr_t      data_out,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ls_pkg::ls_attr_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("attribute FIFO overflow");

    no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("attribute FIFO underflow");

endmodule

`default_nettype wire

// File: source/ls_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module ls_load_align (
    input  wire [31:0]            word,
    input  wire ls_pkg::ls_attr_t attr,
    output logic [31:0]           data
);

    logic [15:0] half_sel;
    logic [7:0] byte_sel;

    // Halfword first, then the byte within it
    assign half_sel = attr.byte_addr[1] ? word[31:16] : word[15:0];
    assign byte_sel = attr.byte_addr[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (attr.width)
            ls_pkg::LS_B: data = {{24{byte_sel[7]}}, byte_sel};
            ls_pkg::LS_H: data = {{16{half_sel[15]}}, half_sel};
            ls_pkg::L_BU: data = {24'b0, byte_sel};
            ls_pkg::L_HU: data = {16'b0, half_sel};
            // Word, or an unused encoding
            default: data = word;
        endcase
    end

endmodule

`default_nettype wire

// File: source/ls_local_ram.sv
`timescale 1ns/1ps
`default_nettype none

module ls_local_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire         clk,
    input  wire         req,
    input  wire         is_store,
    input  wire [31:0]  address,
    input  wire [3:0]   be,
    input  wire [31:0]  wdata,
    output logic [31:0] rdata,
    output logic        rvalid
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0] mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index without the byte offset
    assign idx = address[IDX_W+1:2];

    // Store lands on the issue edge
    always_ff @(posedge clk) begin
        if (req && is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Single read stage
    always_ff @(posedge clk) begin
        rvalid <= req & ~is_store;
        if (req && !is_store) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: source/ls_periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ls_periph_regs (
    input  wire         clk,
    input  wire         rst,
    input  wire         req,
    input  wire         is_store,
    input  wire [31:0]  address,
    input  wire [3:0]   be,
    input  wire [31:0]  wdata,
    output logic [31:0] rdata,
    output logic        rvalid
);

    localparam int IDX_W = (ls_pkg::PERIPH_REGS > 1) ? $clog2(ls_pkg::PERIPH_REGS) : 1;

    logic [31:0] regs [ls_pkg::PERIPH_REGS];
    logic [IDX_W-1:0] idx;
    logic s1_valid;
    logic [31:0] s1_data;

    assign idx = address[IDX_W+1:2];

    //////////////////////////////
    // Register file
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ls_pkg::PERIPH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (req && is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    regs[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Two-stage read pipe
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            s1_valid <= req & ~is_store;
            rvalid <= s1_valid;
        end
    end

    // Data sampled at issue, then just carried along
    always_ff @(posedge clk) begin
        if (req && !is_store) begin
            s1_data <= regs[idx];
        end
        if (s1_valid) begin
            rdata <= s1_data;
        end
    end

endmodule

`default_nettype wire

// File: source/ls_pkg.sv
`default_nettype none

package ls_pkg;

    //////////////////////////////
    // Sizes and address map
    //////////////////////////////

    localparam int ID_W = 4;

    // Peripheral window sits high, RAM starts at zero
    localparam logic [31:0] PERIPH_BASE = 32'h8000_0000;
    localparam int PERIPH_REGS = 8;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Access width, RISC-V fn3 field of loads and stores
    typedef enum logic [2:0] {
        LS_B = 3'b000,
        LS_H = 3'b001,
        LS_W = 3'b010,
        L_BU = 3'b100,
        L_HU = 3'b101
    } ls_fn3_t;

    // Cause values as in mcause
    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED  = 4'd4,
        LOAD_ACCESS_FAULT     = 4'd5,
        STORE_ADDR_MISALIGNED = 4'd6,
        STORE_ACCESS_FAULT    = 4'd7
    } ls_exc_t;

    typedef enum logic {
        UNIT_RAM    = 1'b0,
        UNIT_PERIPH = 1'b1
    } ls_unit_t;

    // Per-load info kept until the data comes back
    typedef struct packed {
        ls_fn3_t          width;
        logic [1:0]       byte_addr;
        logic [ID_W-1:0]  id;
        ls_unit_t         unit;
    } ls_attr_t;

endpackage

`default_nettype wire

// File: sources.f
source/ls_pkg.sv
source/ls_addr_gen.sv
source/ls_local_ram.sv
source/ls_periph_regs.sv
source/ls_attr_fifo.sv
source/ls_load_align.sv
source/load_store_unit.sv
sim/tb_load_store_unit.sv
